// File: src/xbus_pkg.sv
// System bus types
`default_nettype none

package xbus_pkg;

   localparam int ADDR_W = 22;
   localparam int DATA_W = 32;

   typedef logic [ADDR_W-1:0] bus_addr_t;
   typedef logic [DATA_W-1:0] bus_data_t;

   // Held by a master for as long as its req is high
   typedef struct packed {
      bus_addr_t addr;
      bus_data_t wdata;
      logic      write;
   } bus_req_t;

   // Valid while ack is high, err only on timeout
   typedef struct packed {
      bus_data_t rdata;
      logic      err;
   } bus_rsp_t;

   typedef enum logic [2:0] {
      ARB_IDLE,
      CPU_REQ,
      CPU_WAIT,
      DMA_REQ,
      DMA_WAIT
   } arb_state_e;

   typedef enum logic [1:0] {
      DISK_NOP   = 2'd0,
      DISK_READ  = 2'd1,
      DISK_WRITE = 2'd2
   } disk_op_e;

   typedef enum logic [1:0] {
      DSK_IDLE,
      BUS_REQ,
      BUS_REL,
      DONE
   } disk_state_e;

endpackage

`default_nettype wire

// File: src/xbus_map_pkg.sv
// System bus address map
`default_nettype none

package xbus_map_pkg;

   localparam xbus_pkg::bus_addr_t RAM_BASE  = 22'h000000;
   localparam xbus_pkg::bus_addr_t IO_BASE   = 22'h3FFF00;
   localparam xbus_pkg::bus_addr_t DISK_BASE = 22'h3FFF10;

   // Words claimed by each register device
   localparam int DEV_SPAN = 16;

   localparam logic [3:0] IO_SCRATCH = 4'd0;
   localparam logic [3:0] IO_KBD     = 4'd1;
   localparam logic [3:0] IO_STATUS  = 4'd2;
   localparam logic [3:0] IO_IEN     = 4'd3;

   localparam logic [3:0] DISK_ADDR   = 4'd0;
   localparam logic [3:0] DISK_COUNT  = 4'd1;
   localparam logic [3:0] DISK_CMD    = 4'd2;
   localparam logic [3:0] DISK_STATUS = 4'd3;

   typedef enum logic [1:0] {
      DEV_NONE,
      DEV_RAM,
      DEV_IO,
      DEV_DISK
   } dev_e;

endpackage

`default_nettype wire

// File: src/xbus_ram.sv
// Word RAM slave
`timescale 1ns/1ps
`default_nettype none

module xbus_ram #(
   parameter int RAM_WORDS = 1024,
   parameter int RAM_WAIT  = 2
) (
   input  logic               clk,
   input  logic               reset,
   input  logic               sel,
   input  xbus_pkg::bus_req_t cmd,
   output logic               ack,
   output xbus_pkg::bus_rsp_t rsp
);
   import xbus_pkg::*;

   localparam int IDX_W = (RAM_WORDS > 1) ? $clog2(RAM_WORDS) : 1;
   localparam int CNT_W = (RAM_WAIT > 0) ? $clog2(RAM_WAIT + 1) : 1;

   bus_data_t        mem [RAM_WORDS];
   bus_data_t        rdata_q;
   logic [CNT_W-1:0] wait_cnt;
   logic             fire;

   // Last wait cycle, the access happens here
   assign fire = sel && !ack && (wait_cnt == CNT_W'(RAM_WAIT));

   always_ff @(posedge clk) begin
      if (reset) begin
         ack      <= 1'b0;
         wait_cnt <= '0;
      end else if (!sel) begin
         ack      <= 1'b0;
         wait_cnt <= '0;
      end else if (fire) begin
         ack <= 1'b1;
      end else if (!ack) begin
         wait_cnt <= wait_cnt + 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (fire) begin
         if (cmd.write) begin
            mem[cmd.addr[IDX_W-1:0]] <= cmd.wdata;
         end else begin
            rdata_q <= mem[cmd.addr[IDX_W-1:0]];
         end
      end
   end

   assign rsp = '{rdata: rdata_q, err: 1'b0};

endmodule

`default_nettype wire

// File: src/xbus_io.sv
// I/O register slave
`timescale 1ns/1ps
`default_nettype none

module xbus_io (
   input  logic               clk,
   input  logic               reset,
   input  logic               sel,
   input  xbus_pkg::bus_req_t cmd,
   output logic               ack,
   output xbus_pkg::bus_rsp_t rsp,
   input  logic [15:0]        kb_data,
   input  logic               kb_strobe,
   output logic               irq
);
   import xbus_pkg::*;
   import xbus_map_pkg::*;

   bus_data_t   scratch;
   bus_data_t   rdata_q;
   logic [15:0] kb_code;
   logic        kb_ready;
   logic        ien;
   logic [3:0]  off;
   logic        access;

   assign off    = cmd.addr[3:0];
   assign access = sel && !ack;

   // Ack follows select by one cycle on both edges
   always_ff @(posedge clk) begin
      if (reset) begin
         ack      <= 1'b0;
         kb_ready <= 1'b0;
         ien      <= 1'b0;
      end else begin
         ack <= sel;
         if (access && cmd.write && off == IO_IEN) begin
            ien <= cmd.wdata[0];
         end
         // A new key beats the read that clears ready
         if (kb_strobe) begin
            kb_ready <= 1'b1;
         end else if (access && !cmd.write && off == IO_KBD) begin
            kb_ready <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (kb_strobe) begin
         kb_code <= kb_data;
      end
      if (access && cmd.write && off == IO_SCRATCH) begin
         scratch <= cmd.wdata;
      end
      if (access && !cmd.write) begin
         case (off)
            IO_SCRATCH: rdata_q <= scratch;
            IO_KBD:     rdata_q <= DATA_W'(kb_code);
            IO_STATUS:  rdata_q <= DATA_W'(kb_ready);
            IO_IEN:     rdata_q <= DATA_W'(ien);
            default:    rdata_q <= '0;
         endcase
      end
   end

   assign rsp = '{rdata: rdata_q, err: 1'b0};
   assign irq = kb_ready && ien;

endmodule

`default_nettype wire

// File: src/xbus_disk.sv
// Block device controller
`timescale 1ns/1ps
`default_nettype none

module xbus_disk #(
   parameter int SECTOR_WORDS = 16
) (
   input  logic                clk,
   input  logic                reset,
   input  logic                sel,
   input  xbus_pkg::bus_req_t  cmd,
   output logic                ack,
   output xbus_pkg::bus_rsp_t  rsp,
   output logic                dma_req,
   output xbus_pkg::bus_req_t  dma_cmd,
   input  logic                dma_ack,
   input  xbus_pkg::bus_rsp_t  dma_rsp,
   input  xbus_pkg::bus_data_t bd_in_data,
   input  logic                bd_in_valid,
   output xbus_pkg::bus_data_t bd_out_data,
   output logic                bd_out_valid,
   output logic                irq
);
   import xbus_pkg::*;
   import xbus_map_pkg::*;

   localparam int PTR_W = (SECTOR_WORDS > 1) ? $clog2(SECTOR_WORDS) : 1;
   localparam logic [PTR_W-1:0] LAST = PTR_W'(SECTOR_WORDS - 1);

   bus_data_t        sbuf [SECTOR_WORDS];
   logic [PTR_W-1:0] fill_ptr;
   logic [PTR_W-1:0] rd_ptr;
   disk_state_e      state;
   disk_op_e         op_q;
   disk_op_e         new_op;
   bus_addr_t        dma_addr;
   logic [15:0]      dma_count;
   bus_data_t        rdata_q;
   logic             busy;
   logic             done;
   logic [3:0]       off;
   logic             access;
   logic             start;
   logic             word_done;

   assign off       = cmd.addr[3:0];
   assign access    = sel && !ack;
   assign new_op    = disk_op_e'(cmd.wdata[1:0]);
   assign start     = access && cmd.write && off == DISK_CMD && state == DSK_IDLE &&
                      (new_op == DISK_READ || new_op == DISK_WRITE);
   assign word_done = state == BUS_REQ && dma_ack;

   ////////////////////
   // Drive side fill

   always_ff @(posedge clk) begin
      if (reset) begin
         fill_ptr <= '0;
      end else if (bd_in_valid) begin
         fill_ptr <= (fill_ptr == LAST) ? '0 : fill_ptr + 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (bd_in_valid) begin
         sbuf[fill_ptr] <= bd_in_data;
      end
   end

   ////////////////////
   // DMA master, one handshake per word

   always_ff @(posedge clk) begin
      if (reset) begin
         state        <= DSK_IDLE;
         op_q         <= DISK_NOP;
         dma_req      <= 1'b0;
         dma_count    <= '0;
         rd_ptr       <= '0;
         busy         <= 1'b0;
         done         <= 1'b0;
         bd_out_valid <= 1'b0;
         ack          <= 1'b0;
      end else begin
         ack          <= sel;
         bd_out_valid <= 1'b0;
         if (access && cmd.write && off == DISK_COUNT && !busy) begin
            dma_count <= cmd.wdata[15:0];
         end
         if (access && !cmd.write && off == DISK_STATUS) begin
            done <= 1'b0;
         end
         case (state)
            DSK_IDLE: begin
               if (start) begin
                  op_q    <= new_op;
                  busy    <= 1'b1;
                  rd_ptr  <= '0;
                  dma_req <= dma_count != '0;
                  state   <= (dma_count == '0) ? DONE : BUS_REQ;
               end
            end
            BUS_REQ: begin
               if (dma_ack) begin
                  dma_req      <= 1'b0;
                  bd_out_valid <= op_q == DISK_WRITE;
                  dma_count    <= dma_count - 1'b1;
                  rd_ptr       <= (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;
                  state        <= BUS_REL;
               end
            end
            // Bus given back here so the CPU can get in between words
            BUS_REL: begin
               if (!dma_ack) begin
                  dma_req <= dma_count != '0;
                  state   <= (dma_count == '0) ? DONE : BUS_REQ;
               end
            end
            DONE: begin
               busy  <= 1'b0;
               done  <= 1'b1;
               state <= DSK_IDLE;
            end
            default: state <= DSK_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (access && cmd.write && off == DISK_ADDR && !busy) begin
         dma_addr <= cmd.wdata[ADDR_W-1:0];
      end else if (word_done) begin
         dma_addr <= dma_addr + 1'b1;
      end
      if (word_done) begin
         bd_out_data <= dma_rsp.rdata;
      end
      if (access && !cmd.write) begin
         case (off)
            DISK_ADDR:   rdata_q <= DATA_W'(dma_addr);
            DISK_COUNT:  rdata_q <= DATA_W'(dma_count);
            DISK_CMD:    rdata_q <= DATA_W'(op_q);
            DISK_STATUS: rdata_q <= DATA_W'({done, busy});
            default:     rdata_q <= '0;
         endcase
      end
   end

   // READ writes buffer words into RAM
   assign dma_cmd = '{addr: dma_addr, wdata: sbuf[rd_ptr], write: op_q == DISK_READ};
   assign rsp     = '{rdata: rdata_q, err: 1'b0};
   assign irq     = done;

endmodule

`default_nettype wire

// File: src/busint.sv
// Bus interface and arbiter
`timescale 1ns/1ps
`default_nettype none

module busint #(
   parameter int RAM_WORDS      = 1024,
   parameter int TIMEOUT_CYCLES = 63
) (
   input  logic               clk,
   input  logic               reset,
   input  logic               cpu_req,
   input  xbus_pkg::bus_req_t cpu_cmd,
   output logic               cpu_ack,
   output xbus_pkg::bus_rsp_t cpu_rsp,
   output logic               cpu_irq,
   input  logic               dma_req,
   input  xbus_pkg::bus_req_t dma_cmd,
   output logic               dma_ack,
   output xbus_pkg::bus_rsp_t dma_rsp,
   output xbus_pkg::bus_req_t slv_cmd,
   output logic               ram_sel,
   output logic               io_sel,
   output logic               disk_sel,
   input  logic               ram_ack,
   input  logic               io_ack,
   input  logic               disk_ack,
   input  xbus_pkg::bus_rsp_t ram_rsp,
   input  xbus_pkg::bus_rsp_t io_rsp,
   input  xbus_pkg::bus_rsp_t disk_rsp,
   input  logic               io_irq,
   input  logic               disk_irq
);
   import xbus_pkg::*;
   import xbus_map_pkg::*;

   localparam int TMO_W = $clog2(TIMEOUT_CYCLES + 1);

   arb_state_e       state;
   dev_e             dev_q;
   logic [TMO_W-1:0] tmo_cnt;
   logic             tmo_ack;
   logic             cpu_grant;
   logic             dma_grant;
   logic             bus_req;
   logic             slv_ack;
   bus_rsp_t         slv_rsp;

   // Offsets are wrapped, so one unsigned compare covers each region
   function automatic dev_e decode(input bus_addr_t a);
      if (bus_addr_t'(a - RAM_BASE) < bus_addr_t'(RAM_WORDS)) begin
         return DEV_RAM;
      end else if (bus_addr_t'(a - IO_BASE) < bus_addr_t'(DEV_SPAN)) begin
         return DEV_IO;
      end else if (bus_addr_t'(a - DISK_BASE) < bus_addr_t'(DEV_SPAN)) begin
         return DEV_DISK;
      end
      return DEV_NONE;
   endfunction

   ////////////////////
   // Arbiter FSM, CPU first, no pre-emption

   always_ff @(posedge clk) begin
      if (reset) begin
         state   <= ARB_IDLE;
         dev_q   <= DEV_NONE;
         tmo_cnt <= '0;
         tmo_ack <= 1'b0;
      end else begin
         case (state)
            ARB_IDLE: begin
               if (cpu_req) begin
                  dev_q   <= decode(cpu_cmd.addr);
                  tmo_cnt <= TMO_W'(TIMEOUT_CYCLES);
                  state   <= CPU_REQ;
               end else if (dma_req) begin
                  dev_q <= DEV_RAM;
                  state <= DMA_REQ;
               end
            end
            CPU_REQ: begin
               if (slv_ack) begin
                  state <= CPU_WAIT;
               end else if (tmo_cnt == '0) begin
                  tmo_ack <= 1'b1;
                  state   <= CPU_WAIT;
               end else begin
                  tmo_cnt <= tmo_cnt - 1'b1;
               end
            end
            CPU_WAIT: begin
               if (!cpu_req && !slv_ack) begin
                  tmo_ack <= 1'b0;
                  state   <= ARB_IDLE;
               end
            end
            DMA_REQ: begin
               if (slv_ack) begin
                  state <= DMA_WAIT;
               end
            end
            DMA_WAIT: begin
               if (!dma_req && !slv_ack) begin
                  state <= ARB_IDLE;
               end
            end
            default: state <= ARB_IDLE;
         endcase
      end
   end

   ////////////////////
   // Request and response routing

   assign cpu_grant = state == CPU_REQ || state == CPU_WAIT;
   assign dma_grant = state == DMA_REQ || state == DMA_WAIT;
   assign bus_req   = dma_grant ? dma_req : (cpu_grant && cpu_req);
   assign slv_cmd   = dma_grant ? dma_cmd : cpu_cmd;

   assign ram_sel  = bus_req && dev_q == DEV_RAM;
   assign io_sel   = bus_req && dev_q == DEV_IO;
   assign disk_sel = bus_req && dev_q == DEV_DISK;

   always_comb begin
      case (dev_q)
         DEV_RAM: begin
            slv_ack = ram_ack;
            slv_rsp = ram_rsp;
         end
         DEV_IO: begin
            slv_ack = io_ack;
            slv_rsp = io_rsp;
         end
         DEV_DISK: begin
            slv_ack = disk_ack;
            slv_rsp = disk_rsp;
         end
         default: begin
            slv_ack = 1'b0;
            slv_rsp = '0;
         end
      endcase
   end

   // Timed out access reads back zero
   assign cpu_ack = tmo_ack || (cpu_grant && slv_ack);
   assign cpu_rsp = tmo_ack ? '{rdata: '0, err: 1'b1} : slv_rsp;
   assign dma_ack = dma_grant && slv_ack;
   assign dma_rsp = ram_rsp;
   assign cpu_irq = io_irq || disk_irq;

endmodule

`default_nettype wire

// File: src/xbus_top.sv
// System bus top level
`timescale 1ns/1ps
`default_nettype none

module xbus_top #(
   parameter int RAM_WORDS      = 1024,
   parameter int RAM_WAIT       = 2,
   parameter int TIMEOUT_CYCLES = 63,
   parameter int SECTOR_WORDS   = 16
) (
   input  logic                clk,
   input  logic                reset,
   input  logic                cpu_req,
   input  xbus_pkg::bus_req_t  cpu_cmd,
   output logic                cpu_ack,
   output xbus_pkg::bus_rsp_t  cpu_rsp,
   output logic                cpu_irq,
   input  logic [15:0]         kb_data,
   input  logic                kb_strobe,
   input  xbus_pkg::bus_data_t bd_in_data,
   input  logic                bd_in_valid,
   output xbus_pkg::bus_data_t bd_out_data,
   output logic                bd_out_valid
);
   import xbus_pkg::*;

   bus_req_t dma_cmd;
   bus_req_t slv_cmd;
   bus_rsp_t dma_rsp;
   bus_rsp_t ram_rsp;
   bus_rsp_t io_rsp;
   bus_rsp_t disk_rsp;
   logic     dma_req;
   logic     dma_ack;
   logic     ram_sel;
   logic     io_sel;
   logic     disk_sel;
   logic     ram_ack;
   logic     io_ack;
   logic     disk_ack;
   logic     io_irq;
   logic     disk_irq;

   busint #(
      .RAM_WORDS      (RAM_WORDS),
      .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
   ) u_busint (
      .clk      (clk),
      .reset    (reset),
      .cpu_req  (cpu_req),
      .cpu_cmd  (cpu_cmd),
      .cpu_ack  (cpu_ack),
      .cpu_rsp  (cpu_rsp),
      .cpu_irq  (cpu_irq),
      .dma_req  (dma_req),
      .dma_cmd  (dma_cmd),
      .dma_ack  (dma_ack),
      .dma_rsp  (dma_rsp),
      .slv_cmd  (slv_cmd),
      .ram_sel  (ram_sel),
      .io_sel   (io_sel),
      .disk_sel (disk_sel),
      .ram_ack  (ram_ack),
      .io_ack   (io_ack),
      .disk_ack (disk_ack),
      .ram_rsp  (ram_rsp),
      .io_rsp   (io_rsp),
      .disk_rsp (disk_rsp),
      .io_irq   (io_irq),
      .disk_irq (disk_irq)
   );

   xbus_ram #(
      .RAM_WORDS (RAM_WORDS),
      .RAM_WAIT  (RAM_WAIT)
   ) u_ram (
      .clk   (clk),
      .reset (reset),
      .sel   (ram_sel),
      .cmd   (slv_cmd),
      .ack   (ram_ack),
      .rsp   (ram_rsp)
   );

   xbus_io u_io (
      .clk       (clk),
      .reset     (reset),
      .sel       (io_sel),
      .cmd       (slv_cmd),
      .ack       (io_ack),
      .rsp       (io_rsp),
      .kb_data   (kb_data),
      .kb_strobe (kb_strobe),
      .irq       (io_irq)
   );

   // Disk is both a register slave and the second bus master
   xbus_disk #(
      .SECTOR_WORDS (SECTOR_WORDS)
   ) u_disk (
      .clk          (clk),
      .reset        (reset),
      .sel          (disk_sel),
      .cmd          (slv_cmd),
      .ack          (disk_ack),
      .rsp          (disk_rsp),
      .dma_req      (dma_req),
      .dma_cmd      (dma_cmd),
      .dma_ack      (dma_ack),
      .dma_rsp      (dma_rsp),
      .bd_in_data   (bd_in_data),
      .bd_in_valid  (bd_in_valid),
      .bd_out_data  (bd_out_data),
      .bd_out_valid (bd_out_valid),
      .irq          (disk_irq)
   );

endmodule

`default_nettype wire

// File: sim/xbus_clkgen.sv
// Testbench clock and reset
`timescale 1ns/1ps
`default_nettype none

module xbus_clkgen #(
   parameter int PERIOD_NS    = 100,
   parameter int RESET_CYCLES = 8
) (
   output logic clk,
   output logic reset
);

   initial begin
      clk = 1'b0;
      forever #(PERIOD_NS / 2) clk = ~clk;
   end

   // Released on a rising edge, like every other testbench input
   initial begin
      reset = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk);
      reset <= 1'b0;
   end

endmodule

`default_nettype wire

// File: sim/xbus_tb.sv
// System bus testbench
`timescale 1ns/1ps
`default_nettype none

module xbus_tb;
   import xbus_pkg::*;
   import xbus_map_pkg::*;

   localparam int RAM_WORDS      = 1024;
   localparam int RAM_WAIT       = 2;
   localparam int TIMEOUT_CYCLES = 63;
   localparam int SECTOR_WORDS   = 16;
   localparam int IDX_W          = $clog2(RAM_WORDS);
   localparam int PTR_W          = $clog2(SECTOR_WORDS);
   localparam int ACK_LIMIT      = 1000;
   localparam int IRQ_LIMIT      = 3000;
   localparam int NUM_OPS        = 38;

   localparam bus_addr_t IO_SCR_A   = IO_BASE + bus_addr_t'(IO_SCRATCH);
   localparam bus_addr_t IO_KBD_A   = IO_BASE + bus_addr_t'(IO_KBD);
   localparam bus_addr_t IO_STAT_A  = IO_BASE + bus_addr_t'(IO_STATUS);
   localparam bus_addr_t IO_IEN_A   = IO_BASE + bus_addr_t'(IO_IEN);
   localparam bus_addr_t DK_ADDR_A  = DISK_BASE + bus_addr_t'(DISK_ADDR);
   localparam bus_addr_t DK_COUNT_A = DISK_BASE + bus_addr_t'(DISK_COUNT);
   localparam bus_addr_t DK_CMD_A   = DISK_BASE + bus_addr_t'(DISK_CMD);
   localparam bus_addr_t DK_STAT_A  = DISK_BASE + bus_addr_t'(DISK_STATUS);

   typedef enum logic [2:0] {
      OP_WR,
      OP_RD,
      OP_KBD,
      OP_SECTOR,
      OP_IRQ
   } op_kind_e;

   typedef struct packed {
      op_kind_e  kind;
      bus_addr_t addr;
      bus_data_t data;
      int        rep;
      logic      use_rnd;
      logic      use_model;
      bus_data_t exp_data;
      logic      exp_err;
   } op_t;

   ////////////////////
   // Operation table

   // kind, addr, data, repeat, LFSR data, expect RAM copy, expected rdata, expected err
   localparam op_t OPS [NUM_OPS] = '{
      '{OP_WR,     22'h000010, 32'h0,        1,  1'b1, 1'b0, 32'h0,        1'b0},
      '{OP_WR,     22'h000011, 32'h0,        1,  1'b1, 1'b0, 32'h0,        1'b0},
      '{OP_WR,     22'h0003A5, 32'h0,        1,  1'b1, 1'b0, 32'h0,        1'b0},
      '{OP_WR,     22'h0003FF, 32'h0,        1,  1'b1, 1'b0, 32'h0,        1'b0},
      '{OP_RD,     22'h000010, 32'h0,        1,  1'b0, 1'b1, 32'h0,        1'b0},
      '{OP_RD,     22'h000011, 32'h0,        1,  1'b0, 1'b1, 32'h0,        1'b0},
      '{OP_RD,     22'h0003A5, 32'h0,        1,  1'b0, 1'b1, 32'h0,        1'b0},
      '{OP_RD,     22'h0003FF, 32'h0,        1,  1'b0, 1'b1, 32'h0,        1'b0},
      '{OP_RD,     22'h200000, 32'h0,        1,  1'b0, 1'b0, 32'h0,        1'b1},
      '{OP_RD,     22'h3FFF20, 32'h0,        1,  1'b0, 1'b0, 32'h0,        1'b1},
      '{OP_WR,     IO_SCR_A,   32'hC0DE5A5A, 1,  1'b0, 1'b0, 32'h0,        1'b0},
      '{OP_RD,     IO_SCR_A,   32'h0,        1,  1'b0, 1'b0, 32'hC0DE5A5A, 1'b0},
      '{OP_WR,     IO_IEN_A,   32'h1,        1,  1'b0, 1'b0, 32'h0,        1'b0},
      '{OP_KBD,    22'h0,      32'h1234,     1,  1'b0, 1'b0, 32'h0,        1'b0},
      '{OP_IRQ,    22'h0,      32'h0,        1,  1'b0, 1'b0, 32'h1,        1'b0},
      '{OP_RD,     IO_STAT_A,  32'h0,        1,  1'b0, 1'b0, 32'h1,        1'b0},
      '{OP_RD,     IO_KBD_A,   32'h0,        1,  1'b0, 1'b0, 32'h1234,     1'b0},
      '{OP_IRQ,    22'h0,      32'h0,        1,  1'b0, 1'b0, 32'h0,        1'b0},
      '{OP_SECTOR, 22'h0,      32'h0,        1,  1'b1, 1'b0, 32'h0,        1'b0},
      '{OP_WR,     DK_ADDR_A,  32'h100,      1,  1'b0, 1'b0, 32'h0,        1'b0},
      '{OP_WR,     DK_COUNT_A, 32'h10,       1,  1'b0, 1'b0, 32'h0,        1'b0},
      '{OP_WR,     DK_CMD_A,   32'h1,        1,  1'b0, 1'b0, 32'h0,        1'b0},
      '{OP_WR,     22'h000200, 32'h0,        2,  1'b1, 1'b0, 32'h0,        1'b0},
      '{OP_RD,     22'h000200, 32'h0,        2,  1'b0, 1'b1, 32'h0,        1'b0},
      '{OP_IRQ,    22'h0,      32'h0,        1,  1'b0, 1'b0, 32'h1,        1'b0},
      '{OP_RD,     DK_STAT_A,  32'h0,        1,  1'b0, 1'b0, 32'h2,        1'b0},
      '{OP_IRQ,    22'h0,      32'h0,        1,  1'b0, 1'b0, 32'h0,        1'b0},
      '{OP_RD,     22'h000100, 32'h0,        16, 1'b0, 1'b1, 32'h0,        1'b0},
      '{OP_WR,     22'h000040, 32'h0,        8,  1'b1, 1'b0, 32'h0,        1'b0},
      '{OP_WR,     DK_ADDR_A,  32'h40,       1,  1'b0, 1'b0, 32'h0,        1'b0},
      '{OP_WR,     DK_COUNT_A, 32'h8,        1,  1'b0, 1'b0, 32'h0,        1'b0},
      '{OP_WR,     DK_CMD_A,   32'h2,        1,  1'b0, 1'b0, 32'h0,        1'b0},
      '{OP_RD,     22'h000010, 32'h0,        1,  1'b0, 1'b1, 32'h0,        1'b0},
      '{OP_WR,     22'h000300, 32'h0,        1,  1'b1, 1'b0, 32'h0,        1'b0},
      '{OP_RD,     22'h000300, 32'h0,        1,  1'b0, 1'b1, 32'h0,        1'b0},
      '{OP_IRQ,    22'h0,      32'h0,        1,  1'b0, 1'b0, 32'h1,        1'b0},
      '{OP_RD,     DK_STAT_A,  32'h0,        1,  1'b0, 1'b0, 32'h2,        1'b0},
      '{OP_IRQ,    22'h0,      32'h0,        1,  1'b0, 1'b0, 32'h0,        1'b0}
   };

   logic        clk;
   logic        reset;
   logic        cpu_req;
   bus_req_t    cpu_cmd;
   logic        cpu_ack;
   bus_rsp_t    cpu_rsp;
   logic        cpu_irq;
   logic [15:0] kb_data;
   logic        kb_strobe;
   bus_data_t   bd_in_data;
   logic        bd_in_valid;
   bus_data_t   bd_out_data;
   logic        bd_out_valid;

   // Expected RAM contents and the last sector sent to the disk
   bus_data_t   ram_model [RAM_WORDS];
   bus_data_t   sector_copy [SECTOR_WORDS];
   logic [15:0] lfsr_q;
   logic        aborted;
   int          errors;
   int          timeouts;
   bus_addr_t   dk_addr;
   int          dk_count;
   bus_addr_t   drv_base;
   int          drv_start;
   int          drv_limit    = 0;
   int          drv_seen     = 0;
   int          drive_errors = 0;

   xbus_clkgen u_clkgen (
      .clk   (clk),
      .reset (reset)
   );

   xbus_top #(
      .RAM_WORDS      (RAM_WORDS),
      .RAM_WAIT       (RAM_WAIT),
      .TIMEOUT_CYCLES (TIMEOUT_CYCLES),
      .SECTOR_WORDS   (SECTOR_WORDS)
   ) u_xbus_top (
      .clk          (clk),
      .reset        (reset),
      .cpu_req      (cpu_req),
      .cpu_cmd      (cpu_cmd),
      .cpu_ack      (cpu_ack),
      .cpu_rsp      (cpu_rsp),
      .cpu_irq      (cpu_irq),
      .kb_data      (kb_data),
      .kb_strobe    (kb_strobe),
      .bd_in_data   (bd_in_data),
      .bd_in_valid  (bd_in_valid),
      .bd_out_data  (bd_out_data),
      .bd_out_valid (bd_out_valid)
   );

   ////////////////////
   // Helpers

   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
   endfunction

   // One LFSR step per data bit
   task automatic rand_word(output bus_data_t w);
      w = '0;
      for (int b = 0; b < DATA_W; b++) begin
         w      = {w[DATA_W-2:0], lfsr_q[0]};
         lfsr_q = lfsr_next(lfsr_q);
      end
   endtask

   function automatic logic [IDX_W-1:0] ram_idx(input bus_addr_t a);
      return a[IDX_W-1:0];
   endfunction

   function automatic logic [PTR_W-1:0] sec_idx(input int i);
      return PTR_W'(i % SECTOR_WORDS);
   endfunction

   task automatic check_rsp(input bus_rsp_t got, input bus_rsp_t exp, input string what);
      if (got !== exp) begin
         $display("ERR %0d ns: %s got rdata %h err %b, expected rdata %h err %b",
                  $time, what, got.rdata, got.err, exp.rdata, exp.err);
         errors++;
      end
   endtask

   task automatic check_irq(input logic got, input logic exp);
      if (got !== exp) begin
         $display("ERR %0d ns: cpu_irq %b, expected %b", $time, got, exp);
         errors++;
      end
   endtask

   task automatic check_drive_word(input bus_data_t got);
      bus_data_t exp;
      if (drv_seen >= drv_limit) begin
         $display("Drive emitted an extra word %h at %0d ns", got, $time);
         drive_errors++;
      end else begin
         exp = ram_model[ram_idx(drv_base + bus_addr_t'(drv_seen - drv_start))];
         if (got !== exp) begin
            $display("ERR %0d ns: drive word %0d got %h, expected %h",
                     $time, drv_seen - drv_start, got, exp);
            drive_errors++;
         end
      end
      drv_seen++;
   endtask

   // Tracks what each CPU write means for RAM and the disk
   task automatic note_write(input bus_addr_t a, input bus_data_t w);
      if (a < bus_addr_t'(RAM_WORDS)) begin
         ram_model[ram_idx(a)] = w;
      end else if (a == DK_ADDR_A) begin
         dk_addr = w[ADDR_W-1:0];
      end else if (a == DK_COUNT_A) begin
         dk_count = int'(w[15:0]);
      end else if (a == DK_CMD_A && w[1:0] == DISK_READ) begin
         for (int i = 0; i < dk_count; i++) begin
            ram_model[ram_idx(dk_addr + bus_addr_t'(i))] = sector_copy[sec_idx(i)];
         end
      end else if (a == DK_CMD_A && w[1:0] == DISK_WRITE) begin
         drv_base  = dk_addr;
         drv_start = drv_seen;
         drv_limit = drv_seen + dk_count;
      end
   endtask

   ////////////////////
   // CPU bus access, four phase

   task automatic bus_access(input bus_req_t cmd, output bus_rsp_t rsp, output int lat);
      int n;
      rsp = '0;
      lat = 0;
      n   = 0;
      // Spare edge lets busint get back to IDLE
      repeat (2) @(posedge clk);
      cpu_cmd <= cmd;
      cpu_req <= 1'b1;
      @(negedge clk);
      while (cpu_ack !== 1'b1 && lat < ACK_LIMIT) begin
         @(negedge clk);
         lat++;
      end
      if (cpu_ack !== 1'b1) begin
         $display("Timed out waiting for cpu_ack, address %h", cmd.addr);
         timeouts++;
         aborted = 1'b1;
      end else begin
         rsp = cpu_rsp;
         @(posedge clk);
         cpu_req <= 1'b0;
         @(negedge clk);
         while (cpu_ack !== 1'b0 && n < ACK_LIMIT) begin
            @(negedge clk);
            n++;
         end
         if (cpu_ack !== 1'b0) begin
            $display("cpu_ack never dropped after release, address %h", cmd.addr);
            timeouts++;
            aborted = 1'b1;
         end
      end
   endtask

   task automatic apply_op(input op_t op);
      bus_req_t  cmd;
      bus_rsp_t  rsp;
      bus_rsp_t  exp;
      bus_addr_t a;
      bus_data_t w;
      int        lat;
      int        n;
      case (op.kind)
         OP_WR, OP_RD: begin
            for (int k = 0; k < op.rep && !aborted; k++) begin
               a = op.addr + bus_addr_t'(k);
               w = op.data;
               if (op.use_rnd) begin
                  rand_word(w);
               end
               if (op.kind == OP_WR) begin
                  note_write(a, w);
               end
               cmd = '{addr: a, wdata: w, write: op.kind == OP_WR};
               bus_access(cmd, rsp, lat);
               if (!aborted && op.kind == OP_RD) begin
                  exp = '{rdata: op.use_model ? ram_model[ram_idx(a)] : op.exp_data,
                          err: op.exp_err};
                  check_rsp(rsp, exp, $sformatf("read %h", a));
                  // First edge after the request moves busint into CPU_REQ
                  if (op.exp_err && lat - 1 != TIMEOUT_CYCLES + 1) begin
                     $display("ERR %0d ns: timeout ack after %0d cycles, expected %0d",
                              $time, lat - 1, TIMEOUT_CYCLES + 1);
                     errors++;
                  end
               end
            end
         end
         OP_KBD: begin
            @(posedge clk);
            kb_data   <= op.data[15:0];
            kb_strobe <= 1'b1;
            @(posedge clk);
            kb_strobe <= 1'b0;
         end
         OP_SECTOR: begin
            for (int i = 0; i < SECTOR_WORDS; i++) begin
               rand_word(w);
               sector_copy[sec_idx(i)] = w;
               @(posedge clk);
               bd_in_data  <= w;
               bd_in_valid <= 1'b1;
            end
            @(posedge clk);
            bd_in_valid <= 1'b0;
         end
         OP_IRQ: begin
            n = 0;
            @(negedge clk);
            while (cpu_irq !== op.exp_data[0] && n < IRQ_LIMIT) begin
               @(negedge clk);
               n++;
            end
            check_irq(cpu_irq, op.exp_data[0]);
            if (drv_seen != drv_limit) begin
               $display("ERR %0d ns: drive emitted %0d words, expected %0d",
                        $time, drv_seen - drv_start, drv_limit - drv_start);
               errors++;
            end
         end
         default: begin
            $display("Unknown table entry kind");
            errors++;
         end
      endcase
   endtask

   // Drive side strobe has no back-pressure
   always @(negedge clk) begin
      if (bd_out_valid === 1'b1) begin
         check_drive_word(bd_out_data);
      end
   end

   ////////////////////
   // Main sequence

   initial begin
      int n;
      cpu_req     = 1'b0;
      cpu_cmd     = '0;
      kb_data     = '0;
      kb_strobe   = 1'b0;
      bd_in_data  = '0;
      bd_in_valid = 1'b0;
      lfsr_q      = 16'd91;
      aborted     = 1'b0;
      errors      = 0;
      timeouts    = 0;
      dk_addr     = '0;
      dk_count    = 0;
      drv_base    = '0;
      drv_start   = 0;
      n           = 0;
      while (reset !== 1'b0 && n < 100) begin
         @(negedge clk);
         n++;
      end
      if (reset !== 1'b0) begin
         $display("Reset was never released");
         timeouts++;
         aborted = 1'b1;
      end
      for (int i = 0; i < NUM_OPS && !aborted; i++) begin
         apply_op(OPS[i]);
      end
      $display("errors %0d, drive errors %0d, timeouts %0d", errors, drive_errors, timeouts);
      if (errors == 0 && drive_errors == 0 && timeouts == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: compile.f
src/xbus_pkg.sv
src/xbus_map_pkg.sv
src/xbus_ram.sv
src/xbus_io.sv
src/xbus_disk.sv
src/busint.sv
src/xbus_top.sv
sim/xbus_clkgen.sv
sim/xbus_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the system bus testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing -f compile.f --top-module xbus_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/Vxbus_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "sim failed" "$LOG"; then
   exit 1
fi
if grep -q "sim passed" "$LOG"; then
   exit 0
fi
echo "No result line found in $LOG"
exit 1
